/* castin.f */
+incdir+.
castin_pkg.sv
castin_lane.sv
castin_datapath.sv
castin_stats.sv
castin_ctrl.sv
castin_top.sv
castin_asserts.sv
castin_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the castin testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module castin_tb -f castin.f -o castin_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/castin_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished without errors"
exit 0

/* castin_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "castin_macros.svh"

module castin_tb;

  localparam int NUM_PHASES      = 6;
  localparam int WORDS_PER_PHASE = 200;
  localparam int NUM_SPECIAL     = 13;
  // upper bound on register accesses over the whole run
  localparam int REG_ACCESSES    = NUM_PHASES * 9 + 4;
  localparam int TIMEOUT_NS      = 20 * (NUM_PHASES * WORDS_PER_PHASE + REG_ACCESSES) * 10;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  // not in the register map
  localparam logic [`CASTIN_AXIL_ADDR_W-1:0] ADDR_UNMAPPED = 4'h6;

  // zero, subnormals, e4m3 max and nan, e5m2 inf and nan
  localparam logic [7:0] SPECIAL_BYTES [NUM_SPECIAL] = '{
    8'h00, 8'h80, 8'h01, 8'h04, 8'h07, 8'h7E, 8'hFE,
    8'h7F, 8'hFF, 8'h7C, 8'hFC, 8'h7D, 8'h7B
  };

  logic                      clk_i;
  logic                      arst_n_i;
  logic                      s_aw_valid_i;
  logic                      s_aw_ready_o;
  castin_pkg::axil_aw_t      s_aw_i;
  logic                      s_w_valid_i;
  logic                      s_w_ready_o;
  castin_pkg::axil_w_t       s_w_i;
  logic                      s_b_valid_o;
  logic                      s_b_ready_i;
  castin_pkg::axil_b_t       s_b_o;
  logic                      s_ar_valid_i;
  logic                      s_ar_ready_o;
  castin_pkg::axil_ar_t      s_ar_i;
  logic                      s_r_valid_o;
  logic                      s_r_ready_i;
  castin_pkg::axil_r_t       s_r_o;
  logic                      src_valid_i;
  logic                      src_ready_o;
  logic [`CASTIN_DATA_W-1:0] src_data_i;
  logic                      dst_valid_o;
  logic                      dst_ready_i;
  logic [`CASTIN_DATA_W-1:0] dst_data_o;

  logic [31:0]               rng_state;
  logic [`CASTIN_DATA_W-1:0] exp_q[$];
  logic [1:0]                nan_q[$];
  logic [`CASTIN_CNT_W-1:0]  model_beats;
  logic [`CASTIN_CNT_W-1:0]  model_nans;

  castin_top i_dut (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .s_aw_valid_i (s_aw_valid_i),
    .s_aw_ready_o (s_aw_ready_o),
    .s_aw_i       (s_aw_i),
    .s_w_valid_i  (s_w_valid_i),
    .s_w_ready_o  (s_w_ready_o),
    .s_w_i        (s_w_i),
    .s_b_valid_o  (s_b_valid_o),
    .s_b_ready_i  (s_b_ready_i),
    .s_b_o        (s_b_o),
    .s_ar_valid_i (s_ar_valid_i),
    .s_ar_ready_o (s_ar_ready_o),
    .s_ar_i       (s_ar_i),
    .s_r_valid_o  (s_r_valid_o),
    .s_r_ready_i  (s_r_ready_i),
    .s_r_o        (s_r_o),
    .src_valid_i  (src_valid_i),
    .src_ready_o  (src_ready_o),
    .src_data_i   (src_data_i),
    .dst_valid_o  (dst_valid_o),
    .dst_ready_i  (dst_ready_i),
    .dst_data_o   (dst_data_o)
  );

  bind castin_top castin_asserts i_asserts (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .dst_valid_i (dst_valid_o),
    .dst_ready_i (dst_ready_i),
    .dst_data_i  (dst_data_o),
    .b_valid_i   (s_b_valid_o),
    .b_ready_i   (s_b_ready_i),
    .r_valid_i   (s_r_valid_o),
    .r_ready_i   (s_r_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ####################################################################
  // random source and reference model
  // ####################################################################

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic is_nan_byte(input logic [7:0] b, input castin_pkg::fp8_fmt_e fmt);
    if (fmt == castin_pkg::FMT_E4M3) begin
      return b[6:0] == 7'h7F;
    end
    return (b[6:2] == 5'h1F) && (b[1:0] != 2'h0);
  endfunction

  function automatic logic [15:0] widen_byte(input logic [7:0] b,
                                             input castin_pkg::fp8_fmt_e fmt);
    logic       s;
    logic [3:0] e4;
    logic [2:0] m4;
    int         k;
    logic [9:0] frac;
    s  = b[7];
    e4 = b[6:3];
    m4 = b[2:0];
    if (fmt == castin_pkg::FMT_E5M2) begin
      // nan keeps its payload and gets the quiet bit
      return is_nan_byte(b, fmt) ? ({b, 8'h00} | 16'h0200) : {b, 8'h00};
    end
    if (is_nan_byte(b, fmt)) begin
      return {s, 15'h7E00};
    end
    if (e4 == 4'h0 && m4 == 3'h0) begin
      return {s, 15'h0000};
    end
    if (e4 == 4'h0) begin
      // man * 2^-9 written as 1.f * 2^(k-9)
      k    = m4[2] ? 2 : (m4[1] ? 1 : 0);
      frac = 10'((int'(m4) - (1 << k)) << (10 - k));
      return {s, 5'(k + 6), frac};
    end
    return {s, 5'(e4) + 5'd8, m4, 7'h00};
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] d,
                                                input castin_pkg::cast_cfg_t cfg);
    if (!cfg.enable) begin
      return d;
    end
    return {widen_byte(d[15:8], cfg.src_fmt), widen_byte(d[7:0], cfg.src_fmt)};
  endfunction

  function automatic logic [1:0] expected_nans(input logic [31:0] d,
                                               input castin_pkg::cast_cfg_t cfg);
    if (!cfg.enable) begin
      return 2'd0;
    end
    return {1'b0, is_nan_byte(d[15:8], cfg.src_fmt)} + {1'b0, is_nan_byte(d[7:0], cfg.src_fmt)};
  endfunction

  // first words of a phase carry the special bytes in both lanes
  function automatic logic [31:0] stream_word(input int idx);
    logic [31:0] w;
    w = next_rand();
    if (idx < NUM_SPECIAL) begin
      w[15:0] = {SPECIAL_BYTES[4'((idx + 5) % NUM_SPECIAL)], SPECIAL_BYTES[4'(idx)]};
    end
    return w;
  endfunction

  // ####################################################################
  // compare tasks
  // ####################################################################

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
      $display("Test FAILED");
      $fatal(1, "stream word mismatch");
    end
  endtask

  task automatic check_r(input string name, input castin_pkg::axil_r_t exp,
                         input castin_pkg::axil_r_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected data 0x%08h resp %0d actual data 0x%08h resp %0d",
               $time, name, exp.data, exp.resp, act.data, act.resp);
      $display("Test FAILED");
      $fatal(1, "read response mismatch");
    end
  endtask

  task automatic check_b(input string name, input castin_pkg::axil_b_t exp,
                         input castin_pkg::axil_b_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0t %s expected resp %0d actual resp %0d",
               $time, name, exp.resp, act.resp);
      $display("Test FAILED");
      $fatal(1, "write response mismatch");
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s at t=%0t", what, $time);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // ####################################################################
  // axi4-lite host
  // ####################################################################

  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data, input logic [1:0] resp);
    castin_pkg::axil_b_t exp_b;
    logic [31:0]         r;
    logic                done;
    exp_b.resp = resp;
    @(posedge clk_i);
    s_aw_valid_i  <= 1'b1;
    s_aw_i.addr   <= addr;
    s_aw_i.prot   <= 3'b000;
    s_w_valid_i   <= 1'b1;
    s_w_i.data    <= data;
    s_w_i.strb    <= 4'hF;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      // address and data channels are taken in the same cycle
      if (s_w_ready_o !== s_aw_ready_o) begin
        abort_run("wready and awready differ while both write channels are valid");
      end
      done = s_aw_valid_i && s_aw_ready_o;
    end
    s_aw_valid_i <= 1'b0;
    s_w_valid_i  <= 1'b0;
    r = next_rand();
    s_b_ready_i <= r[0];
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      done = s_b_valid_o && s_b_ready_i;
      if (!done) begin
        r = next_rand();
        s_b_ready_i <= r[0];
      end
    end
    check_b("s_b_o", exp_b, s_b_o);
    s_b_ready_i <= 1'b0;
  endtask

  task automatic reg_read(input logic [3:0] addr, input logic [31:0] data, input logic [1:0] resp);
    castin_pkg::axil_r_t exp_r;
    logic [31:0]         r;
    logic                done;
    exp_r.data = data;
    exp_r.resp = resp;
    @(posedge clk_i);
    s_ar_valid_i <= 1'b1;
    s_ar_i.addr  <= addr;
    s_ar_i.prot  <= 3'b000;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      done = s_ar_valid_i && s_ar_ready_o;
    end
    s_ar_valid_i <= 1'b0;
    r = next_rand();
    s_r_ready_i <= r[0];
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      done = s_r_valid_o && s_r_ready_i;
      if (!done) begin
        r = next_rand();
        s_r_ready_i <= r[0];
      end
    end
    check_r("s_r_o", exp_r, s_r_o);
    s_r_ready_i <= 1'b0;
  endtask

  // ####################################################################
  // stream driver and monitor
  // ####################################################################

  task automatic run_stream(input int n_words, input castin_pkg::cast_cfg_t cfg);
    int          sent;
    int          got;
    logic [31:0] r;
    logic [31:0] exp_word;
    logic [1:0]  exp_nan;
    sent = 0;
    got  = 0;
    while (got < n_words) begin
      @(posedge clk_i);
      if (src_valid_i && src_ready_o) begin
        exp_q.push_back(expected_word(src_data_i, cfg));
        nan_q.push_back(expected_nans(src_data_i, cfg));
        sent++;
      end
      if (dst_valid_o && dst_ready_i) begin
        if (exp_q.size() == 0) begin
          abort_run("output word delivered while none was expected");
        end else begin
          exp_word = exp_q.pop_front();
          exp_nan  = nan_q.pop_front();
          check_word("dst_data_o", exp_word, dst_data_o);
          model_beats = model_beats + 32'd1;
          model_nans  = model_nans + {30'd0, exp_nan};
          got++;
        end
      end
      // hold a word until it is taken
      if (!src_valid_i || src_ready_o) begin
        r = next_rand();
        if (sent < n_words && r[1:0] != 2'b00) begin
          src_valid_i <= 1'b1;
          src_data_i  <= stream_word(sent);
        end else begin
          src_valid_i <= 1'b0;
        end
      end
      r = next_rand();
      dst_ready_i <= (r[3:0] < 4'd11);
    end
    src_valid_i <= 1'b0;
    dst_ready_i <= 1'b1;
    repeat (3) begin
      @(posedge clk_i);
      if (dst_valid_o) begin
        abort_run("extra output word after the stream drained");
      end
    end
    dst_ready_i <= 1'b0;
  endtask

  // ####################################################################
  // main sequence
  // ####################################################################

  initial begin
    castin_pkg::cast_cfg_t cfg;
    logic [31:0]           r;
    arst_n_i     = 1'b0;
    s_aw_valid_i = 1'b0;
    s_aw_i       = '0;
    s_w_valid_i  = 1'b0;
    s_w_i        = '0;
    s_b_ready_i  = 1'b0;
    s_ar_valid_i = 1'b0;
    s_ar_i       = '0;
    s_r_ready_i  = 1'b0;
    src_valid_i  = 1'b0;
    src_data_i   = '0;
    dst_ready_i  = 1'b0;
    rng_state    = 32'd85320;
    model_beats  = '0;
    model_nans   = '0;
    cfg          = '0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    reg_read(castin_pkg::REG_CTRL, 32'd0, RESP_OKAY);
    for (int phase = 0; phase < NUM_PHASES; phase++) begin
      r = next_rand();
      case (phase)
        0:       cfg = castin_pkg::cast_cfg_t'(2'b00);
        1:       cfg = castin_pkg::cast_cfg_t'(2'b01);
        2:       cfg = castin_pkg::cast_cfg_t'(2'b11);
        3:       cfg = castin_pkg::cast_cfg_t'(2'b10);
        default: cfg = castin_pkg::cast_cfg_t'(r[1:0]);
      endcase
      reg_write(castin_pkg::REG_CTRL, {30'd0, cfg}, RESP_OKAY);
      reg_read(castin_pkg::REG_CTRL, {30'd0, cfg}, RESP_OKAY);
      run_stream(WORDS_PER_PHASE, cfg);
      reg_read(castin_pkg::REG_BEATS, model_beats, RESP_OKAY);
      reg_read(castin_pkg::REG_NANS, model_nans, RESP_OKAY);
      if (phase % 2 == 1) begin
        reg_write(castin_pkg::REG_CLEAR, 32'd1, RESP_OKAY);
        model_beats = '0;
        model_nans  = '0;
        reg_read(castin_pkg::REG_BEATS, 32'd0, RESP_OKAY);
        reg_read(castin_pkg::REG_NANS, 32'd0, RESP_OKAY);
        reg_read(castin_pkg::REG_CLEAR, 32'd0, RESP_OKAY);
      end
    end
    // reserved offset, the data differs from the config in both bits
    reg_write(ADDR_UNMAPPED, {30'd0, cfg} ^ 32'h3, RESP_SLVERR);
    reg_read(ADDR_UNMAPPED, 32'd0, RESP_SLVERR);
    reg_read(castin_pkg::REG_CTRL, {30'd0, cfg}, RESP_OKAY);
    $display("Test OK");
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, the run did not complete", TIMEOUT_NS);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* castin_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "castin_macros.svh"

module castin_asserts (
  input logic                      clk_i,
  input logic                      arst_n_i,
  input logic                      dst_valid_i,
  input logic                      dst_ready_i,
  input logic [`CASTIN_DATA_W-1:0] dst_data_i,
  input logic                      b_valid_i,
  input logic                      b_ready_i,
  input logic                      r_valid_i,
  input logic                      r_ready_i
);

  // ####################################################################
  // stream output
  // ####################################################################

  // stalled word stays put
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (dst_valid_i && !dst_ready_i) |=> (dst_valid_i && $stable(dst_data_i)))
  else $error("dst_data_o changed or dst_valid_o dropped under back-pressure");

  assert property (@(posedge clk_i) !arst_n_i |-> !dst_valid_i)
  else $error("dst_valid_o high during reset");

  // ####################################################################
  // register port responses
  // ####################################################################

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (b_valid_i && !b_ready_i) |=> b_valid_i)
  else $error("bvalid dropped before bready");

  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (r_valid_i && !r_ready_i) |=> r_valid_i)
  else $error("rvalid dropped before rready");

endmodule

`default_nettype wire

/* castin_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "castin_macros.svh"

module castin_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // axi4-lite register port
  input  logic                      s_aw_valid_i,
  output logic                      s_aw_ready_o,
  input  castin_pkg::axil_aw_t      s_aw_i,
  input  logic                      s_w_valid_i,
  output logic                      s_w_ready_o,
  input  castin_pkg::axil_w_t       s_w_i,
  output logic                      s_b_valid_o,
  input  logic                      s_b_ready_i,
  output castin_pkg::axil_b_t       s_b_o,
  input  logic                      s_ar_valid_i,
  output logic                      s_ar_ready_o,
  input  castin_pkg::axil_ar_t      s_ar_i,
  output logic                      s_r_valid_o,
  input  logic                      s_r_ready_i,
  output castin_pkg::axil_r_t       s_r_o,
  // stream in
  input  logic                      src_valid_i,
  output logic                      src_ready_o,
  input  logic [`CASTIN_DATA_W-1:0] src_data_i,
  // stream out
  output logic                      dst_valid_o,
  input  logic                      dst_ready_i,
  output logic [`CASTIN_DATA_W-1:0] dst_data_o
);

  castin_pkg::cast_cfg_t    cfg;
  castin_pkg::cast_beat_t   in_beat;
  logic                     clear;
  logic                     out_fire;
  logic [1:0]               nan_cnt;
  logic [`CASTIN_CNT_W-1:0] beats;
  logic [`CASTIN_CNT_W-1:0] nans;

  // current config rides along with the incoming word
  assign in_beat.data = src_data_i;
  assign in_beat.cfg  = cfg;

  assign out_fire = dst_valid_o && dst_ready_i;

  castin_ctrl i_ctrl (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .aw_valid_i (s_aw_valid_i),
    .aw_ready_o (s_aw_ready_o),
    .aw_i       (s_aw_i),
    .w_valid_i  (s_w_valid_i),
    .w_ready_o  (s_w_ready_o),
    .w_i        (s_w_i),
    .b_valid_o  (s_b_valid_o),
    .b_ready_i  (s_b_ready_i),
    .b_o        (s_b_o),
    .ar_valid_i (s_ar_valid_i),
    .ar_ready_o (s_ar_ready_o),
    .ar_i       (s_ar_i),
    .r_valid_o  (s_r_valid_o),
    .r_ready_i  (s_r_ready_i),
    .r_o        (s_r_o),
    .beats_i    (beats),
    .nans_i     (nans),
    .cfg_o      (cfg),
    .clear_o    (clear)
  );

  castin_datapath i_datapath (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (src_valid_i),
    .in_ready_o  (src_ready_o),
    .in_beat_i   (in_beat),
    .out_valid_o (dst_valid_o),
    .out_ready_i (dst_ready_i),
    .out_data_o  (dst_data_o),
    .nan_cnt_o   (nan_cnt)
  );

  castin_stats i_stats (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .clear_i   (clear),
    .fire_i    (out_fire),
    .nan_cnt_i (nan_cnt),
    .beats_o   (beats),
    .nans_o    (nans)
  );

endmodule

`default_nettype wire

/* castin_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "castin_macros.svh"

module castin_ctrl (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     aw_valid_i,
  output logic                     aw_ready_o,
  input  castin_pkg::axil_aw_t     aw_i,
  input  logic                     w_valid_i,
  output logic                     w_ready_o,
  input  castin_pkg::axil_w_t      w_i,
  output logic                     b_valid_o,
  input  logic                     b_ready_i,
  output castin_pkg::axil_b_t      b_o,
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  input  castin_pkg::axil_ar_t     ar_i,
  output logic                     r_valid_o,
  input  logic                     r_ready_i,
  output castin_pkg::axil_r_t      r_o,
  input  logic [`CASTIN_CNT_W-1:0] beats_i,
  input  logic [`CASTIN_CNT_W-1:0] nans_i,
  output castin_pkg::cast_cfg_t    cfg_o,
  output logic                     clear_o
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  castin_pkg::ctrl_state_e   wr_state_q;
  castin_pkg::ctrl_state_e   rd_state_q;
  castin_pkg::reg_addr_e     wr_addr;
  castin_pkg::reg_addr_e     rd_addr;
  castin_pkg::cast_cfg_t     cfg_q;
  logic                      clear_q;
  logic                      wr_fire;
  logic                      rd_fire;
  logic [1:0]                wr_resp;
  castin_pkg::axil_r_t       rd_resp;
  castin_pkg::axil_b_t       b_q;
  castin_pkg::axil_r_t       r_q;

  assign wr_addr = castin_pkg::reg_addr_e'(aw_i.addr);
  assign rd_addr = castin_pkg::reg_addr_e'(ar_i.addr);

  // ####################################################################
  // write channel
  // ####################################################################

  // address and data are taken together in one cycle
  assign wr_fire    = (wr_state_q == castin_pkg::CS_WIDLE) && aw_valid_i && w_valid_i;
  assign aw_ready_o = wr_fire;
  assign w_ready_o  = wr_fire;

  // read-only registers still answer okay
  always_comb begin
    case (wr_addr)
      castin_pkg::REG_CTRL,
      castin_pkg::REG_BEATS,
      castin_pkg::REG_NANS,
      castin_pkg::REG_CLEAR: wr_resp = RESP_OKAY;
      default:               wr_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_state_q <= castin_pkg::CS_WIDLE;
      cfg_q      <= '0;
      clear_q    <= 1'b0;
    end else begin
      clear_q <= 1'b0;
      case (wr_state_q)
        castin_pkg::CS_WIDLE: begin
          if (wr_fire) begin
            wr_state_q <= castin_pkg::CS_WRESP;
            if (wr_addr == castin_pkg::REG_CTRL) begin
              cfg_q <= castin_pkg::cast_cfg_t'(w_i.data[1:0]);
            end
            if (wr_addr == castin_pkg::REG_CLEAR) begin
              clear_q <= 1'b1;
            end
          end
        end
        castin_pkg::CS_WRESP: begin
          if (b_ready_i) begin
            wr_state_q <= castin_pkg::CS_WIDLE;
          end
        end
        default: wr_state_q <= castin_pkg::CS_WIDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_q.resp <= wr_resp;
    end
  end

  // ####################################################################
  // read channel
  // ####################################################################

  assign ar_ready_o = (rd_state_q == castin_pkg::CS_RIDLE);
  assign rd_fire    = ar_ready_o && ar_valid_i;

  always_comb begin
    rd_resp.data = '0;
    rd_resp.resp = RESP_OKAY;
    case (rd_addr)
      castin_pkg::REG_CTRL:  rd_resp.data = {{(`CASTIN_DATA_W-2){1'b0}}, cfg_q};
      castin_pkg::REG_BEATS: rd_resp.data = beats_i;
      castin_pkg::REG_NANS:  rd_resp.data = nans_i;
      // clear is write-only and reads zero
      castin_pkg::REG_CLEAR: rd_resp.data = '0;
      default:               rd_resp.resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_state_q <= castin_pkg::CS_RIDLE;
    end else begin
      case (rd_state_q)
        castin_pkg::CS_RIDLE: begin
          if (rd_fire) begin
            rd_state_q <= castin_pkg::CS_RDATA;
          end
        end
        castin_pkg::CS_RDATA: begin
          if (r_ready_i) begin
            rd_state_q <= castin_pkg::CS_RIDLE;
          end
        end
        default: rd_state_q <= castin_pkg::CS_RIDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_q <= rd_resp;
    end
  end

  assign b_valid_o = (wr_state_q == castin_pkg::CS_WRESP);
  assign b_o       = b_q;
  assign r_valid_o = (rd_state_q == castin_pkg::CS_RDATA);
  assign r_o       = r_q;
  assign cfg_o     = cfg_q;
  assign clear_o   = clear_q;

endmodule

`default_nettype wire

/* castin_stats.sv */
`timescale 1ns/1ps
`default_nettype none

`include "castin_macros.svh"

module castin_stats (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     clear_i,
  input  logic                     fire_i,
  input  logic [1:0]               nan_cnt_i,
  output logic [`CASTIN_CNT_W-1:0] beats_o,
  output logic [`CASTIN_CNT_W-1:0] nans_o
);

  logic [`CASTIN_CNT_W-1:0] beats_q;
  logic [`CASTIN_CNT_W-1:0] nans_q;
  logic [`CASTIN_CNT_W:0]   nans_sum;

  // one extra bit to catch the wrap
  assign nans_sum = {1'b0, nans_q} + {{(`CASTIN_CNT_W-1){1'b0}}, nan_cnt_i};

  // clear takes priority over a handshake in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beats_q <= '0;
      nans_q  <= '0;
    end else if (clear_i) begin
      beats_q <= '0;
      nans_q  <= '0;
    end else if (fire_i) begin
      if (beats_q != '1) begin
        beats_q <= beats_q + 1'b1;
      end
      // saturate at all ones
      if (nans_sum[`CASTIN_CNT_W]) begin
        nans_q <= '1;
      end else begin
        nans_q <= nans_sum[`CASTIN_CNT_W-1:0];
      end
    end
  end

  assign beats_o = beats_q;
  assign nans_o  = nans_q;

endmodule

`default_nettype wire

/* castin_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "castin_macros.svh"

module castin_datapath (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  castin_pkg::cast_beat_t    in_beat_i,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output logic [`CASTIN_DATA_W-1:0] out_data_o,
  output logic [1:0]                nan_cnt_o
);

  logic [`CASTIN_NUM_LANES-1:0]                  lane_nan;
  logic [`CASTIN_NUM_LANES*`CASTIN_DST_W-1:0]    cast_data;
  logic [1:0]                                    nan_sum;
  logic                                          in_fire;
  logic                                          out_valid_q;
  logic [`CASTIN_DATA_W-1:0]                     out_data_q;
  logic [1:0]                                    nan_cnt_q;

  // ####################################################################
  // lane converters
  // ####################################################################

  for (genvar i = 0; i < `CASTIN_NUM_LANES; i++) begin : gen_lane
    castin_lane i_lane (
      .src_i (in_beat_i.data[i*`CASTIN_SRC_W +: `CASTIN_SRC_W]),
      .fmt_i (in_beat_i.cfg.src_fmt),
      .dst_o (cast_data[i*`CASTIN_DST_W +: `CASTIN_DST_W]),
      .nan_o (lane_nan[i])
    );
  end

  // nan lanes only count when casting
  always_comb begin
    nan_sum = 2'd0;
    if (in_beat_i.cfg.enable) begin
      for (int i = 0; i < `CASTIN_NUM_LANES; i++) begin
        nan_sum = nan_sum + 2'(lane_nan[i]);
      end
    end
  end

  // ####################################################################
  // output register
  // ####################################################################

  // empty slot, or the held word leaves this cycle
  assign in_ready_o = !out_valid_q || out_ready_i;
  assign in_fire    = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (in_fire) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      out_data_q <= in_beat_i.cfg.enable ? cast_data : in_beat_i.data;
      nan_cnt_q  <= nan_sum;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;
  assign nan_cnt_o   = nan_cnt_q;

endmodule

`default_nettype wire

/* castin_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "castin_macros.svh"

module castin_lane (
  input  logic [`CASTIN_SRC_W-1:0] src_i,
  input  castin_pkg::fp8_fmt_e     fmt_i,
  output logic [`CASTIN_DST_W-1:0] dst_o,
  output logic                     nan_o
);

  logic       sign;
  logic [3:0] e4_exp;
  logic [2:0] e4_man;
  logic [4:0] e5_exp;
  logic [1:0] e5_man;
  logic [1:0] lead_pos;
  logic [3:0] sub_norm;

  assign sign   = src_i[`CASTIN_SRC_W-1];
  assign e4_exp = src_i[6:3];
  assign e4_man = src_i[2:0];
  assign e5_exp = src_i[6:2];
  assign e5_man = src_i[1:0];

  // position of the leading one in a subnormal e4m3 mantissa
  always_comb begin
    lead_pos = 2'd0;
    for (int i = 0; i < 3; i++) begin
      if (e4_man[i]) begin
        lead_pos = 2'(i);
      end
    end
  end

  // bit 3 ends up as the hidden one, bits 2..0 are the fraction
  assign sub_norm = {1'b0, e4_man} << (2'd3 - lead_pos);

  always_comb begin
    dst_o = '0;
    nan_o = 1'b0;
    if (fmt_i == castin_pkg::FMT_E4M3) begin
      if (e4_exp == 4'hF && e4_man == 3'h7) begin
        // only nan encoding of e4m3, becomes a quiet fp16 nan
        dst_o = {sign, 15'h7E00};
        nan_o = 1'b1;
      end else if (e4_exp == 4'h0) begin
        if (e4_man == 3'h0) begin
          dst_o = {sign, 15'h0000};
        end else begin
          // value is man * 2^-9, rebias to fp16 normal
          dst_o = {sign, 5'(lead_pos) + 5'd6, sub_norm[2:0], 7'h00};
        end
      end else begin
        // bias 7 to bias 15
        dst_o = {sign, 5'(e4_exp) + 5'd8, e4_man, 7'h00};
      end
    end else begin
      // e5m2 is the top byte of fp16
      dst_o = {src_i, 8'h00};
      if (e5_exp == 5'h1F && e5_man != 2'h0) begin
        // quiet bit
        dst_o[9] = 1'b1;
        nan_o    = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* castin_pkg.sv */
`default_nettype none

`include "castin_macros.svh"

package castin_pkg;

  // ####################################################################
  // encodings
  // ####################################################################

  // source fp8 flavour
  typedef enum logic {
    FMT_E4M3 = 1'b0,
    FMT_E5M2 = 1'b1
  } fp8_fmt_e;

  // register offsets on the axi4-lite port
  typedef enum logic [`CASTIN_AXIL_ADDR_W-1:0] {
    REG_CTRL  = 4'h0,
    REG_BEATS = 4'h4,
    REG_NANS  = 4'h8,
    REG_CLEAR = 4'hC
  } reg_addr_e;

  // write fsm uses the first two, read fsm the last two
  typedef enum logic [1:0] {
    CS_WIDLE,
    CS_WRESP,
    CS_RIDLE,
    CS_RDATA
  } ctrl_state_e;

  // ####################################################################
  // configuration and stream beat
  // ####################################################################

  // bit 0 enable, bit 1 source format
  typedef struct packed {
    fp8_fmt_e src_fmt;
    logic     enable;
  } cast_cfg_t;

  // config travels with every accepted word
  typedef struct packed {
    cast_cfg_t                 cfg;
    logic [`CASTIN_DATA_W-1:0] data;
  } cast_beat_t;

  // ####################################################################
  // axi4-lite channel payloads
  // ####################################################################

  typedef struct packed {
    logic [`CASTIN_AXIL_ADDR_W-1:0] addr;
    logic [2:0]                     prot;
  } axil_aw_t;

  typedef struct packed {
    logic [`CASTIN_DATA_W-1:0]   data;
    logic [`CASTIN_DATA_W/8-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  typedef struct packed {
    logic [`CASTIN_AXIL_ADDR_W-1:0] addr;
    logic [2:0]                     prot;
  } axil_ar_t;

  typedef struct packed {
    logic [`CASTIN_DATA_W-1:0] data;
    logic [1:0]                resp;
  } axil_r_t;

endpackage

`default_nettype wire

/* castin_macros.svh */
`ifndef CASTIN_MACROS_SVH
`define CASTIN_MACROS_SVH

// ####################################################################
// stream geometry
// ####################################################################

// one stream word
`define CASTIN_DATA_W 32

// narrow source lane, FP8
`define CASTIN_SRC_W 8

// widened lane, FP16
`define CASTIN_DST_W 16

// two FP8 lanes in the low half of a word
`define CASTIN_NUM_LANES 2

// ####################################################################
// register port
// ####################################################################

`define CASTIN_AXIL_ADDR_W 4

// beat and nan counters
`define CASTIN_CNT_W 32

`endif
